/* divFix.sv */
module divFix import mduPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] remIn,
    input  logic [DATA_W-1:0] quoIn,
    input  logic              negQuo,
    input  logic              negRem,
    output logic [DATA_W-1:0] quotient,
    output logic [DATA_W-1:0] remainder
);

    logic [DATA_W-1:0] quoSigned;
    logic [DATA_W-1:0] remSigned;

    // Truncating division, so the remainder follows the dividend sign
    assign quoSigned = negQuo ? -quoIn : quoIn;
    assign remSigned = negRem ? -remIn : remIn;

    // A zero divisor needs no special case here
    // Every step subtracts nothing, giving an all ones magnitude quotient
    // and the dividend back as remainder
    always_ff @(posedge clk) begin
        if (rst) begin
            quotient  <= '0;
            remainder <= '0;
        end else begin
            quotient  <= quoSigned;
            remainder <= remSigned;
        end
    end

endmodule

/* divPrep.sv */
module divPrep import mduPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              signedOp,
    input  logic [DATA_W-1:0] dividend,
    input  logic [DATA_W-1:0] divisor,
    output logic [DATA_W-1:0] remIn,
    output logic [DATA_W-1:0] quoIn,
    output logic [DATA_W-1:0] divisorOut,
    output logic              negQuo,
    output logic              negRem
);

    logic              dividendNeg;
    logic              divisorNeg;
    logic [DATA_W-1:0] dividendMag;
    logic [DATA_W-1:0] divisorMag;

    assign dividendNeg = signedOp & dividend[DATA_W-1];
    assign divisorNeg  = signedOp & divisor[DATA_W-1];

    // The most negative value maps onto itself, which reads correctly as unsigned
    assign dividendMag = dividendNeg ? -dividend : dividend;
    assign divisorMag  = divisorNeg ? -divisor : divisor;

    always_ff @(posedge clk) begin
        if (rst) begin
            remIn      <= '0;
            quoIn      <= '0;
            divisorOut <= '0;
            negQuo     <= 1'b0;
            negRem     <= 1'b0;
        end else begin
            // Quotient bits replace dividend bits from the bottom as the steps go
            remIn      <= '0;
            quoIn      <= dividendMag;
            divisorOut <= divisorMag;
            negQuo     <= dividendNeg ^ divisorNeg;
            negRem     <= dividendNeg;
        end
    end

endmodule

/* divStage.sv */
module divStage import mduPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] remIn,
    input  logic [DATA_W-1:0] quoIn,
    input  logic [DATA_W-1:0] divisorIn,
    input  logic              negQuoIn,
    input  logic              negRemIn,
    output logic [DATA_W-1:0] remOut,
    output logic [DATA_W-1:0] quoOut,
    output logic [DATA_W-1:0] divisorOut,
    output logic              negQuoOut,
    output logic              negRemOut
);

    logic [DATA_W:0]   shifted;
    logic [DATA_W+1:0] diff;
    logic              fits;

    // The remainder stays below the divisor, so one extra bit holds the shift
    assign shifted = {remIn, quoIn[DATA_W-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisorIn};
    assign fits    = ~diff[DATA_W+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            remOut     <= '0;
            quoOut     <= '0;
            divisorOut <= '0;
            negQuoOut  <= 1'b0;
            negRemOut  <= 1'b0;
        end else begin
            remOut     <= fits ? diff[DATA_W-1:0] : shifted[DATA_W-1:0];
            quoOut     <= {quoIn[DATA_W-2:0], fits};
            divisorOut <= divisorIn;
            negQuoOut  <= negQuoIn;
            negRemOut  <= negRemIn;
        end
    end

endmodule

/* flist.f */
mduPkg.sv
mulPipe.sv
divPrep.sv
divStage.sv
divFix.sv
wbSequencer.sv
mduTop.sv
mduTb.sv

/* mduPkg.sv */
package mduPkg;

    localparam int DATA_W  = 32;
    localparam int PREG_W  = 6;
    localparam int ROBID_W = 5;

    // The product leaves the last of these registers
    localparam int MUL_CYCLE = 3;

    // One restoring step per quotient bit
    localparam int DIV_STEPS = DATA_W;

    // Operand preparation and sign fixup each add one register
    localparam int DIV_CYCLE = DIV_STEPS + 2;

    typedef enum logic [1:0] {
        MUL  = 2'd0,
        MULU = 2'd1,
        DIV  = 2'd2,
        DIVU = 2'd3
    } MduOp;

    function automatic logic isMulOp(input MduOp op);
        return (op == MUL) || (op == MULU);
    endfunction

    function automatic logic isDivOp(input MduOp op);
        return (op == DIV) || (op == DIVU);
    endfunction

    // Signed variants treat both operands as two's complement
    function automatic logic isSignedOp(input MduOp op);
        return (op == MUL) || (op == DIV);
    endfunction

endpackage

/* mduTb.sv */
module mduTb import mduPkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MUL_TESTS    = 40;
    localparam int DIV_TESTS    = 40;
    localparam int CORNER_TESTS = 10;
    localparam int B2B_CYCLES   = 80;
    localparam int TEST_COUNT   = MUL_TESTS + DIV_TESTS + CORNER_TESTS + B2B_CYCLES;
    localparam int MAX_CYCLES   = 8192;

    logic               clk;
    logic               rst;
    logic               issue;
    MduOp               op;
    logic [DATA_W-1:0]  srcA;
    logic [DATA_W-1:0]  srcB;
    logic [PREG_W-1:0]  dstHi;
    logic [PREG_W-1:0]  dstLo;
    logic [ROBID_W-1:0] robIdHi;
    logic [ROBID_W-1:0] robIdLo;
    logic               wbEn;
    logic [PREG_W-1:0]  wbRd;
    logic [DATA_W-1:0]  wbData;
    logic               finish;
    logic [ROBID_W-1:0] finishId;

    logic [31:0] lfsrState = 32'd87;
    int          cycle = 0;
    int          lastSlot = 0;
    int          checked = 0;
    int          valueErrors = 0;
    int          missingErrors = 0;
    int          unexpectedErrors = 0;

    // Expected writebacks, indexed by the cycle in which they must appear
    logic               expValid [MAX_CYCLES];
    logic [PREG_W-1:0]  expRd    [MAX_CYCLES];
    logic [ROBID_W-1:0] expId    [MAX_CYCLES];
    logic [DATA_W-1:0]  expData  [MAX_CYCLES];
    int                 expKind  [MAX_CYCLES];

    mduTop mduTop_i (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .op       (op),
        .srcA     (srcA),
        .srcB     (srcB),
        .dstHi    (dstHi),
        .dstLo    (dstLo),
        .robIdHi  (robIdHi),
        .robIdLo  (robIdLo),
        .wbEn     (wbEn),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .finish   (finish),
        .finishId (finishId)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // The Hi result sits above the Lo result, so a divide returns remainder above quotient
    function automatic logic [2*DATA_W-1:0] expectedPair(input MduOp kind,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] wideA;
        logic [2*DATA_W-1:0] wideB;
        logic                negA;
        logic                negB;
        logic [DATA_W-1:0]   magA;
        logic [DATA_W-1:0]   magB;
        logic [DATA_W-1:0]   q;
        logic [DATA_W-1:0]   r;
        if (kind == MUL || kind == MULU) begin
            wideA = (kind == MUL) ? {{DATA_W{a[DATA_W-1]}}, a} : {{DATA_W{1'b0}}, a};
            wideB = (kind == MUL) ? {{DATA_W{b[DATA_W-1]}}, b} : {{DATA_W{1'b0}}, b};
            return wideA * wideB;
        end
        negA = (kind == DIV) && a[DATA_W-1];
        negB = (kind == DIV) && b[DATA_W-1];
        magA = negA ? -a : a;
        magB = negB ? -b : b;
        // A zero divisor gives an all ones magnitude quotient and the dividend as remainder
        if (magB == '0) begin
            q = '1;
            r = magA;
        end else begin
            q = magA / magB;
            r = magA % magB;
        end
        if (negA ^ negB) begin
            q = -q;
        end
        if (negA) begin
            r = -r;
        end
        return {r, q};
    endfunction

    function automatic int latencyOf(input MduOp kind);
        return (kind == MUL || kind == MULU) ? MUL_CYCLE : DIV_CYCLE;
    endfunction

    function automatic logic slotsFree(input int hiAt);
        return !expValid[hiAt] && !expValid[hiAt+1];
    endfunction

    function automatic string testName(input int kind);
        case (kind)
            0: return "mulRandom";
            1: return "divRandom";
            2: return "divCorner";
            default: return "backToBack";
        endcase
    endfunction

    task automatic recordWriteback(input int at, input logic [PREG_W-1:0] rd,
            input logic [ROBID_W-1:0] id, input logic [DATA_W-1:0] data, input int kind);
        expValid[at] = 1'b1;
        expRd[at]    = rd;
        expId[at]    = id;
        expData[at]  = data;
        expKind[at]  = kind;
    endtask

    // Called right after a rising edge, the DUT samples these at the next one
    task automatic driveIssue(input MduOp kind, input logic [DATA_W-1:0] a,
            input logic [DATA_W-1:0] b, input int testKind);
        logic [2*DATA_W-1:0] pair;
        logic [PREG_W-1:0]   rdHi;
        logic [PREG_W-1:0]   rdLo;
        logic [ROBID_W-1:0]  idHi;
        logic [ROBID_W-1:0]  idLo;
        int                  hiAt;
        rdHi = randBits(PREG_W);
        rdLo = randBits(PREG_W);
        idHi = randBits(ROBID_W);
        idLo = idHi + 1'b1;
        hiAt = cycle + 1 + latencyOf(kind);
        pair = expectedPair(kind, a, b);
        issue   <= 1'b1;
        op      <= kind;
        srcA    <= a;
        srcB    <= b;
        dstHi   <= rdHi;
        dstLo   <= rdLo;
        robIdHi <= idHi;
        robIdLo <= idLo;
        recordWriteback(hiAt, rdHi, idHi, pair[2*DATA_W-1:DATA_W], testKind);
        recordWriteback(hiAt + 1, rdLo, idLo, pair[DATA_W-1:0], testKind);
        // A divide issued earlier can still be due after a later multiply
        if (hiAt + 1 > lastSlot) begin
            lastSlot = hiAt + 1;
        end
    endtask

    task automatic issueWhenFree(input MduOp kind, input logic [DATA_W-1:0] a,
            input logic [DATA_W-1:0] b, input int testKind);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            issue <= 1'b0;
            if (slotsFree(cycle + 1 + latencyOf(kind))) begin
                driveIssue(kind, a, b, testKind);
                done = 1'b1;
            end
        end
    endtask

    task automatic issueEither(input logic preferMul);
        MduOp              mulKind;
        MduOp              divKind;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        mulKind = randBits(1) ? MUL : MULU;
        divKind = randBits(1) ? DIV : DIVU;
        a = randBits(DATA_W);
        b = randBits(DATA_W);
        @(posedge clk);
        issue <= 1'b0;
        if (preferMul && slotsFree(cycle + 1 + MUL_CYCLE)) begin
            driveIssue(mulKind, a, b, 3);
        end else if (slotsFree(cycle + 1 + DIV_CYCLE)) begin
            driveIssue(divKind, a, b, 3);
        end else if (slotsFree(cycle + 1 + MUL_CYCLE)) begin
            driveIssue(mulKind, a, b, 3);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            issue <= 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (cycle > 0 && cycle < MAX_CYCLES) begin
            if (expValid[cycle]) begin
                checked++;
                if (wbEn !== 1'b1) begin
                    $display("Missing writeback for %s at cycle %0d, wbEn was not raised",
                             testName(expKind[cycle]), cycle);
                    missingErrors++;
                end else begin
                    if (finish !== 1'b1) begin
                        $display("FAILED %s finish expected 1 actual %b",
                                 testName(expKind[cycle]), finish);
                        valueErrors++;
                    end
                    if (wbRd !== expRd[cycle]) begin
                        $display("FAILED %s wbRd expected %0d actual %0d",
                                 testName(expKind[cycle]), expRd[cycle], wbRd);
                        valueErrors++;
                    end
                    if (finishId !== expId[cycle]) begin
                        $display("FAILED %s finishId expected %0d actual %0d",
                                 testName(expKind[cycle]), expId[cycle], finishId);
                        valueErrors++;
                    end
                    if (wbData !== expData[cycle]) begin
                        $display("FAILED %s wbData expected %h actual %h",
                                 testName(expKind[cycle]), expData[cycle], wbData);
                        valueErrors++;
                    end
                end
            end else if (wbEn !== 1'b0 || finish !== 1'b0) begin
                $display("Unexpected writeback at cycle %0d to register %0d with id %0d",
                         cycle, wbRd, finishId);
                unexpectedErrors++;
            end
        end
    end

    initial begin
        #((RESET_CYCLES + TEST_COUNT * DIV_CYCLE + 100) * CLK_PERIOD);
        $display("Watchdog expired at time %0t before the tests completed", $time);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        MduOp              kind;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        int                shift;
        for (int i = 0; i < MAX_CYCLES; i++) begin
            expValid[i] = 1'b0;
        end
        rst     = 1'b1;
        issue   = 1'b0;
        op      = MUL;
        srcA    = '0;
        srcB    = '0;
        dstHi   = '0;
        dstLo   = '0;
        robIdHi = '0;
        robIdLo = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Nothing issued yet, so the checker flags any writeback here
        idleCycles(20);

        for (int i = 0; i < MUL_TESTS; i++) begin
            kind = randBits(1) ? MUL : MULU;
            a = randBits(DATA_W);
            b = randBits(DATA_W);
            issueWhenFree(kind, a, b, 0);
        end

        // Shorter divisors give quotients with more than a bit or two set
        for (int i = 0; i < DIV_TESTS; i++) begin
            kind = randBits(1) ? DIV : DIVU;
            a = randBits(DATA_W);
            b = randBits(DATA_W);
            shift = randBits(5);
            if (randBits(1)) begin
                b = b >> shift;
            end else begin
                b = $signed(b) >>> shift;
            end
            issueWhenFree(kind, a, b, 1);
        end

        issueWhenFree(DIV, 32'h1234_5678, 32'h0000_0000, 2);
        issueWhenFree(DIV, 32'hedcb_a988, 32'h0000_0000, 2);
        issueWhenFree(DIVU, 32'hf000_0001, 32'h0000_0000, 2);
        issueWhenFree(DIV, 32'h8000_0000, 32'hffff_ffff, 2);
        issueWhenFree(DIVU, 32'h8000_0000, 32'hffff_ffff, 2);
        issueWhenFree(DIV, 32'h8000_0000, 32'h0000_0001, 2);
        issueWhenFree(DIV, 32'h0000_0005, 32'h0000_0007, 2);
        issueWhenFree(DIV, 32'hffff_fffb, 32'h0000_0007, 2);
        issueWhenFree(DIV, 32'h0000_0007, 32'hffff_fff7, 2);
        issueWhenFree(DIVU, 32'h0000_0003, 32'hffff_fff0, 2);

        for (int i = 0; i < B2B_CYCLES; i++) begin
            issueEither(i % 2 == 0);
        end

        while (cycle <= lastSlot) begin
            @(posedge clk);
            issue <= 1'b0;
        end
        idleCycles(4);
        @(negedge clk);

        $display("Errors: %0d wrong value, %0d missing, %0d unexpected, %0d writebacks checked",
                 valueErrors, missingErrors, unexpectedErrors, checked);
        if (valueErrors == 0 && missingErrors == 0 && unexpectedErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* mduTop.sv */
module mduTop import mduPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  MduOp               op,
    input  logic [DATA_W-1:0]  srcA,
    input  logic [DATA_W-1:0]  srcB,
    input  logic [PREG_W-1:0]  dstHi,
    input  logic [PREG_W-1:0]  dstLo,
    input  logic [ROBID_W-1:0] robIdHi,
    input  logic [ROBID_W-1:0] robIdLo,
    output logic               wbEn,
    output logic [PREG_W-1:0]  wbRd,
    output logic [DATA_W-1:0]  wbData,
    output logic               finish,
    output logic [ROBID_W-1:0] finishId
);

    logic                mulIssue;
    logic                divIssue;
    logic                signedOp;
    logic [DATA_W-1:0]   mulA;
    logic [DATA_W-1:0]   mulB;
    logic [DATA_W-1:0]   divA;
    logic [DATA_W-1:0]   divB;
    logic [2*DATA_W-1:0] product;
    logic [DATA_W-1:0]   quotient;
    logic [DATA_W-1:0]   remainder;

    // Index 0 is the prep output, index DIV_STEPS feeds the fixup
    logic [DATA_W-1:0]   remChain     [DIV_STEPS+1];
    logic [DATA_W-1:0]   quoChain     [DIV_STEPS+1];
    logic [DATA_W-1:0]   divisorChain [DIV_STEPS+1];
    logic [DIV_STEPS:0]  negQuoChain;
    logic [DIV_STEPS:0]  negRemChain;

    assign mulIssue = issue && isMulOp(op);
    assign divIssue = issue && isDivOp(op);
    assign signedOp = isSignedOp(op);

    // Operands reach a unit only when it is issued, so the other stays quiet
    assign mulA = mulIssue ? srcA : '0;
    assign mulB = mulIssue ? srcB : '0;
    assign divA = divIssue ? srcA : '0;
    assign divB = divIssue ? srcB : '0;

    mulPipe mulPipe_i (
        .clk      (clk),
        .rst      (rst),
        .signedOp (signedOp),
        .a        (mulA),
        .b        (mulB),
        .product  (product)
    );

    divPrep divPrep_i (
        .clk        (clk),
        .rst        (rst),
        .signedOp   (signedOp),
        .dividend   (divA),
        .divisor    (divB),
        .remIn      (remChain[0]),
        .quoIn      (quoChain[0]),
        .divisorOut (divisorChain[0]),
        .negQuo     (negQuoChain[0]),
        .negRem     (negRemChain[0])
    );

    for (genvar i = 0; i < DIV_STEPS; i++) begin : stageGen
        divStage divStage_i (
            .clk        (clk),
            .rst        (rst),
            .remIn      (remChain[i]),
            .quoIn      (quoChain[i]),
            .divisorIn  (divisorChain[i]),
            .negQuoIn   (negQuoChain[i]),
            .negRemIn   (negRemChain[i]),
            .remOut     (remChain[i+1]),
            .quoOut     (quoChain[i+1]),
            .divisorOut (divisorChain[i+1]),
            .negQuoOut  (negQuoChain[i+1]),
            .negRemOut  (negRemChain[i+1])
        );
    end

    divFix divFix_i (
        .clk       (clk),
        .rst       (rst),
        .remIn     (remChain[DIV_STEPS]),
        .quoIn     (quoChain[DIV_STEPS]),
        .negQuo    (negQuoChain[DIV_STEPS]),
        .negRem    (negRemChain[DIV_STEPS]),
        .quotient  (quotient),
        .remainder (remainder)
    );

    wbSequencer wbSequencer_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .op        (op),
        .dstHi     (dstHi),
        .dstLo     (dstLo),
        .robIdHi   (robIdHi),
        .robIdLo   (robIdLo),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .wbEn      (wbEn),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .finish    (finish),
        .finishId  (finishId)
    );

endmodule

/* mulPipe.sv */
module mulPipe import mduPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  signedOp,
    input  logic [DATA_W-1:0]     a,
    input  logic [DATA_W-1:0]     b,
    output logic [2*DATA_W-1:0]   product
);

    logic signed [DATA_W:0]     aExt;
    logic signed [DATA_W:0]     bExt;
    logic signed [2*DATA_W+1:0] fullProd;
    logic [2*DATA_W-1:0]        prodPipe [MUL_CYCLE];

    // One extra bit lets a single signed multiplier cover both variants
    assign aExt = {signedOp & a[DATA_W-1], a};
    assign bExt = {signedOp & b[DATA_W-1], b};

    assign fullProd = aExt * bExt;

    // The multiply sits in front of a plain register chain so synthesis
    // can push the partial product logic into the later stages
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_CYCLE; i++) begin
                prodPipe[i] <= '0;
            end
        end else begin
            prodPipe[0] <= fullProd[2*DATA_W-1:0];
            for (int i = 1; i < MUL_CYCLE; i++) begin
                prodPipe[i] <= prodPipe[i-1];
            end
        end
    end

    assign product = prodPipe[MUL_CYCLE-1];

endmodule

/* wbSequencer.sv */
module wbSequencer import mduPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  MduOp                op,
    input  logic [PREG_W-1:0]   dstHi,
    input  logic [PREG_W-1:0]   dstLo,
    input  logic [ROBID_W-1:0]  robIdHi,
    input  logic [ROBID_W-1:0]  robIdLo,
    input  logic [2*DATA_W-1:0] product,
    input  logic [DATA_W-1:0]   quotient,
    input  logic [DATA_W-1:0]   remainder,
    output logic                wbEn,
    output logic [PREG_W-1:0]   wbRd,
    output logic [DATA_W-1:0]   wbData,
    output logic                finish,
    output logic [ROBID_W-1:0]  finishId
);

    typedef enum logic [2:0] {idle, mulHi, mulLo, divHi, divLo} WbState;

    WbState state;
    WbState nextState;

    logic mulIssue;
    logic divIssue;

    // Tag entries carry the destination register above the ROB id
    logic [PREG_W+ROBID_W-1:0] tagHi;
    logic [PREG_W+ROBID_W-1:0] tagLo;
    logic [PREG_W+ROBID_W-1:0] outTag;

    // Entry 0 of each line lines up with the cycle its result is written
    logic [MUL_CYCLE-1:0]      mulHiValid;
    logic [MUL_CYCLE:0]        mulLoValid;
    logic [DIV_CYCLE-1:0]      divHiValid;
    logic [DIV_CYCLE:0]        divLoValid;
    logic [PREG_W+ROBID_W-1:0] mulHiTag [MUL_CYCLE];
    logic [PREG_W+ROBID_W-1:0] mulLoTag [MUL_CYCLE+1];
    logic [PREG_W+ROBID_W-1:0] divHiTag [DIV_CYCLE];
    logic [PREG_W+ROBID_W-1:0] divLoTag [DIV_CYCLE+1];

    logic [DATA_W-1:0] loData;

    assign mulIssue = issue && isMulOp(op);
    assign divIssue = issue && isDivOp(op);
    assign tagHi    = {dstHi, robIdHi};
    assign tagLo    = {dstLo, robIdLo};

    always_ff @(posedge clk) begin
        if (rst) begin
            mulHiValid <= '0;
            mulLoValid <= '0;
            divHiValid <= '0;
            divLoValid <= '0;
        end else begin
            mulHiValid <= {mulIssue, mulHiValid[MUL_CYCLE-1:1]};
            mulLoValid <= {mulIssue, mulLoValid[MUL_CYCLE:1]};
            divHiValid <= {divIssue, divHiValid[DIV_CYCLE-1:1]};
            divLoValid <= {divIssue, divLoValid[DIV_CYCLE:1]};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < MUL_CYCLE - 1; i++) begin
            mulHiTag[i] <= mulHiTag[i+1];
        end
        for (int i = 0; i < MUL_CYCLE; i++) begin
            mulLoTag[i] <= mulLoTag[i+1];
        end
        for (int i = 0; i < DIV_CYCLE - 1; i++) begin
            divHiTag[i] <= divHiTag[i+1];
        end
        for (int i = 0; i < DIV_CYCLE; i++) begin
            divLoTag[i] <= divLoTag[i+1];
        end
        mulHiTag[MUL_CYCLE-1] <= tagHi;
        mulLoTag[MUL_CYCLE]   <= tagLo;
        divHiTag[DIV_CYCLE-1] <= tagHi;
        divLoTag[DIV_CYCLE]   <= tagLo;
    end

    // Look one entry ahead so the Hi state starts with its result
    always_comb begin
        case (state)
            mulHi: begin
                nextState = mulLo;
            end
            divHi: begin
                nextState = divLo;
            end
            default: begin
                if (mulHiValid[1]) begin
                    nextState = mulHi;
                end else if (divHiValid[1]) begin
                    nextState = divHi;
                end else begin
                    nextState = idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // The low word or quotient is gone by the Lo slot, so keep a copy
    always_ff @(posedge clk) begin
        if (state == mulHi) begin
            loData <= product[DATA_W-1:0];
        end else if (state == divHi) begin
            loData <= quotient;
        end
    end

    always_comb begin
        wbEn   = 1'b0;
        wbData = '0;
        outTag = '0;
        case (state)
            mulHi: begin
                wbEn   = mulHiValid[0];
                wbData = product[2*DATA_W-1:DATA_W];
                outTag = mulHiTag[0];
            end
            mulLo: begin
                wbEn   = mulLoValid[0];
                wbData = loData;
                outTag = mulLoTag[0];
            end
            divHi: begin
                wbEn   = divHiValid[0];
                wbData = remainder;
                outTag = divHiTag[0];
            end
            divLo: begin
                wbEn   = divLoValid[0];
                wbData = loData;
                outTag = divLoTag[0];
            end
            default: begin
                wbEn = 1'b0;
            end
        endcase
    end

    // Each writeback also retires its ROB entry in the same cycle
    assign finish           = wbEn;
    assign {wbRd, finishId} = outTag;

endmodule
